// ==== filelist.f ====
+incdir+hw
hw/histoDataPkg.sv
hw/histoCtrlPkg.sv
hw/binMapper.sv
hw/hisBuilderReg.sv
hw/acqFrameCounter.sv
hw/peakTracker.sv
hw/histoReadout.sv
hw/sifhHistogram.sv
tb/sifhHistogram_checker.sv
tb/sifhHistogramTb.sv

// ==== hw/acqFrameCounter.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module acqFrameCounter (
    input  logic clk,
    input  logic res,
    input  logic acqEnd,
    input  logic busy,
    output logic frameDone,
    output logic nextFlag
);

    localparam int CW = ($clog2(`NUM_ACQ) > 0) ? $clog2(`NUM_ACQ) : 1;

    logic [CW-1:0] acqCnt;
    logic lastAcq;

    assign lastAcq = (acqCnt == CW'(`NUM_ACQ - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqCnt    <= '0;
            frameDone <= 1'b0;
            nextFlag  <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            // strobes during readout do not count
            if (acqEnd && !busy) begin
                if (lastAcq) begin
                    acqCnt    <= '0;
                    frameDone <= 1'b1;
                    nextFlag  <= ~nextFlag;   // flips once per frame
                end else begin
                    acqCnt <= acqCnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/binMapper.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module binMapper (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    hit,
    input  histoDataPkg::timeCode_t hitTime,
    input  histoCtrlPkg::histMode_e mode,
    input  histoDataPkg::timeCode_t fineOffset,
    input  logic                    busy,
    output logic                    incValid,
    output histoDataPkg::binAddr_t  incAddr
);

    logic [`TDC_W:0] fineDiff;          // one extra bit catches hitTime < fineOffset
    logic fineInWin;
    histoDataPkg::binAddr_t coarseBin;
    histoDataPkg::binAddr_t mapBin;
    logic mapOk;

    // coarse keeps the top bits of the code
    assign coarseBin = hitTime[`TDC_W-1 -: `NB];

    // negative difference wraps above the window and fails the check too
    assign fineDiff  = {1'b0, hitTime} - {1'b0, fineOffset};
    assign fineInWin = (fineDiff < `NUM_BINS);

    always_comb begin
        if (mode == histoCtrlPkg::FINE) begin
            mapBin = fineDiff[`NB-1:0];
            mapOk  = fineInWin;
        end else begin
            mapBin = coarseBin;
            mapOk  = 1'b1;                // full range, nothing dropped
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            incValid <= 1'b0;
        end else begin
            incValid <= hit && !busy && mapOk;  // readout blocks new hits
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            incAddr <= mapBin;
        end
    end

endmodule

// ==== hw/hisBuilderReg.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module hisBuilderReg (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    incValid,
    input  histoDataPkg::binAddr_t  incAddr,
    input  logic                    rdValid,
    input  histoDataPkg::binAddr_t  rdAddr,
    input  logic                    clearAll,
    output logic                    updValid,
    output histoDataPkg::binAddr_t  updAddr,
    output histoDataPkg::binCount_t updCount,
    output logic                    rdDataValid,
    output histoDataPkg::binCount_t rdCount
);

    histoDataPkg::binCount_t binCnt [`NUM_BINS];
    logic [`NUM_BINS-1:0] binVld;       // set on first hit, cleared per frame
    histoDataPkg::binCount_t curCount;
    histoDataPkg::binCount_t nextCount;

    assign curCount = binCnt[incAddr];

    // stale words behind a clear valid bit are never added to
    always_comb begin
        if (!binVld[incAddr]) begin
            nextCount = histoDataPkg::binCount_t'(1);
        end else if (&curCount) begin
            nextCount = curCount;         // saturated
        end else begin
            nextCount = curCount + 1'b1;
        end
    end

    // valid bits, wiped in one cycle at the end of a frame
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binVld <= '0;
        end else if (clearAll) begin
            binVld <= '0;
        end else if (incValid) begin
            binVld[incAddr] <= 1'b1;
        end
    end

    // count array written in place, so back-to-back hits chain
    always_ff @(posedge clk) begin
        if (incValid) begin
            binCnt[incAddr] <= nextCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            updValid    <= 1'b0;
            rdDataValid <= 1'b0;
        end else begin
            updValid    <= incValid;
            rdDataValid <= rdValid;
        end
    end

    always_ff @(posedge clk) begin
        if (incValid) begin
            updAddr  <= incAddr;
            updCount <= nextCount;        // new value goes to the peak tracker
        end
        if (rdValid) begin
            rdCount <= binVld[rdAddr] ? binCnt[rdAddr] : '0;  // empty bin reads 0
        end
    end

endmodule

// ==== hw/histoCtrlPkg.sv ====
// control encodings for mapping and readout
package histoCtrlPkg;

    // coarse spans the full time range, fine is a window at an offset
    typedef enum logic {
        COARSE,
        FINE
    } histMode_e;

    // readout sequencer states
    typedef enum logic [2:0] {
        IDLE,   // collecting hits
        DRAIN,  // let in-flight hits land
        SWEEP,  // issue one read per bin
        PEAK,   // wait for last read word
        CLEAR   // report peak, wipe bins
    } readState_e;

endpackage

// ==== hw/histoDataPkg.sv ====
`include "sifhHistogram_params.svh"

// data widths shared by the histogram datapath
package histoDataPkg;

    // index of one histogram bin
    typedef logic [`NB-1:0] binAddr_t;

    // hits collected in one bin
    typedef logic [`PEAK_MAX-1:0] binCount_t;

    // raw arrival time of a photon hit
    typedef logic [`TDC_W-1:0] timeCode_t;

endpackage

// ==== hw/histoReadout.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module histoReadout (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    frameDone,
    input  logic                    rdDataValid,
    input  histoDataPkg::binCount_t rdCount,
    input  histoDataPkg::binAddr_t  peakAddr,
    input  histoDataPkg::binCount_t peakCount,
    output logic                    busy,
    output logic                    rdValid,
    output histoDataPkg::binAddr_t  rdAddr,
    output logic                    clearAll,
    output logic                    binValid,
    output histoDataPkg::binAddr_t  binAddr,
    output histoDataPkg::binCount_t binCount,
    output logic                    peakValid,
    output histoDataPkg::binAddr_t  peakOut,
    output histoDataPkg::binCount_t peakCountOut
);

    localparam int DRAIN_LAST = 1;       // two drain cycles

    histoCtrlPkg::readState_e state;
    histoDataPkg::binAddr_t addrCnt;     // drain count, then read address
    histoDataPkg::binAddr_t retAddr;     // address of the word coming back

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= histoCtrlPkg::IDLE;
            addrCnt   <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= (state == histoCtrlPkg::PEAK);
            case (state)
                histoCtrlPkg::IDLE: begin
                    addrCnt <= '0;
                    if (frameDone) begin
                        state <= histoCtrlPkg::DRAIN;
                    end
                end
                histoCtrlPkg::DRAIN: begin
                    if (addrCnt == histoDataPkg::binAddr_t'(DRAIN_LAST)) begin
                        state   <= histoCtrlPkg::SWEEP;
                        addrCnt <= '0;
                    end else begin
                        addrCnt <= addrCnt + 1'b1;
                    end
                end
                histoCtrlPkg::SWEEP: begin
                    addrCnt <= addrCnt + 1'b1;  // wraps to 0 after the last bin
                    if (addrCnt == histoDataPkg::binAddr_t'(`NUM_BINS - 1)) begin
                        state <= histoCtrlPkg::PEAK;
                    end
                end
                histoCtrlPkg::PEAK:  state <= histoCtrlPkg::CLEAR;  // last word returns here
                histoCtrlPkg::CLEAR: state <= histoCtrlPkg::IDLE;
                default:             state <= histoCtrlPkg::IDLE;
            endcase
        end
    end

    // peak is final once the sweep is done, latch it with the strobe
    always_ff @(posedge clk) begin
        if (state == histoCtrlPkg::PEAK) begin
            peakOut      <= peakAddr;
            peakCountOut <= peakCount;
        end
        if (rdValid) begin
            retAddr <= rdAddr;
        end
    end

    assign busy     = (state != histoCtrlPkg::IDLE);
    assign rdValid  = (state == histoCtrlPkg::SWEEP);
    assign rdAddr   = addrCnt;
    assign clearAll = (state == histoCtrlPkg::CLEAR);
    assign binValid = rdDataValid;
    assign binAddr  = retAddr;
    assign binCount = rdCount;

endmodule

// ==== hw/peakTracker.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module peakTracker (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    updValid,
    input  histoDataPkg::binAddr_t  updAddr,
    input  histoDataPkg::binCount_t updCount,
    input  logic                    clearAll,
    output histoDataPkg::binAddr_t  peakAddr,
    output histoDataPkg::binCount_t peakCount
);

    logic newPeak;

    // strictly greater, so a tie keeps the bin that got there first
    assign newPeak = updValid && (updCount > peakCount);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakAddr  <= '0;
            peakCount <= '0;
        end else if (clearAll) begin
            peakAddr  <= '0;               // fresh frame
            peakCount <= '0;
        end else if (newPeak) begin
            peakAddr  <= updAddr;
            peakCount <= updCount;
        end
    end

endmodule

// ==== hw/sifhHistogram.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module sifhHistogram (
    input  logic                    clk,
    input  logic                    res,
    input  logic                    hit,
    input  histoDataPkg::timeCode_t hitTime,
    input  histoCtrlPkg::histMode_e mode,
    input  histoDataPkg::timeCode_t fineOffset,
    input  logic                    acqEnd,
    output logic                    binValid,
    output histoDataPkg::binAddr_t  binAddr,
    output histoDataPkg::binCount_t binCount,
    output logic                    peakValid,
    output histoDataPkg::binAddr_t  peakAddr,
    output histoDataPkg::binCount_t peakCount,
    output logic                    nextFlag,
    output logic                    busy
);

    logic                    incValid;
    histoDataPkg::binAddr_t  incAddr;
    logic                    updValid;
    histoDataPkg::binAddr_t  updAddr;
    histoDataPkg::binCount_t updCount;
    logic                    rdValid;
    histoDataPkg::binAddr_t  rdAddr;
    logic                    rdDataValid;
    histoDataPkg::binCount_t rdCount;
    logic                    clearAll;
    logic                    frameDone;
    histoDataPkg::binAddr_t  trkAddr;    // running peak inside the tracker
    histoDataPkg::binCount_t trkCount;

    binMapper uBinMapper (
        .clk(clk), .res(res), .hit(hit), .hitTime(hitTime), .mode(mode),
        .fineOffset(fineOffset), .busy(busy), .incValid(incValid), .incAddr(incAddr)
    );

    hisBuilderReg uBuilder (
        .clk(clk), .res(res), .incValid(incValid), .incAddr(incAddr),
        .rdValid(rdValid), .rdAddr(rdAddr), .clearAll(clearAll),
        .updValid(updValid), .updAddr(updAddr), .updCount(updCount),
        .rdDataValid(rdDataValid), .rdCount(rdCount)
    );

    acqFrameCounter uFrameCnt (
        .clk(clk), .res(res), .acqEnd(acqEnd), .busy(busy),
        .frameDone(frameDone), .nextFlag(nextFlag)
    );

    peakTracker uPeak (
        .clk(clk), .res(res), .updValid(updValid), .updAddr(updAddr),
        .updCount(updCount), .clearAll(clearAll),
        .peakAddr(trkAddr), .peakCount(trkCount)
    );

    histoReadout uReadout (
        .clk(clk), .res(res), .frameDone(frameDone), .rdDataValid(rdDataValid),
        .rdCount(rdCount), .peakAddr(trkAddr), .peakCount(trkCount),
        .busy(busy), .rdValid(rdValid), .rdAddr(rdAddr), .clearAll(clearAll),
        .binValid(binValid), .binAddr(binAddr), .binCount(binCount),
        .peakValid(peakValid), .peakOut(peakAddr), .peakCountOut(peakCount)
    );

endmodule

// ==== hw/sifhHistogram_params.svh ====
`ifndef SIFH_HISTOGRAM_PARAMS_SVH
`define SIFH_HISTOGRAM_PARAMS_SVH

// histogram geometry

// bin index width
`define NB 6

// one register per bin, 2**NB of them
`define NUM_BINS 64

// count width per bin, saturates at all ones
`define PEAK_MAX 21

// hit time code from the TDC
`define TDC_W 10

// acquisition-end strobes that make up one frame
`define NUM_ACQ 8

`endif

// ==== tb/sifhHistogramTb.sv ====
`timescale 1ns/1ps
`include "sifhHistogram_params.svh"

module sifhHistogramTb;

    localparam int PERIOD       = 100;
    localparam int FRAME_CYCLES = 2 * `NUM_ACQ + `NUM_BINS + 20;
    localparam int HIT_CYCLES   = 480;    // all hit and setup cycles of the tests
    localparam int TEST_CYCLES  = 7 * FRAME_CYCLES + HIT_CYCLES + 10;

    logic clk;
    logic res;
    logic hit;
    logic acqEnd;
    histoDataPkg::timeCode_t hitTime;
    histoDataPkg::timeCode_t fineOffset;
    histoCtrlPkg::histMode_e mode;
    logic binValid;
    logic peakValid;
    logic nextFlag;
    logic busy;
    histoDataPkg::binAddr_t  binAddr;
    histoDataPkg::binAddr_t  peakAddr;
    histoDataPkg::binCount_t binCount;
    histoDataPkg::binCount_t peakCount;

    // reference histogram
    histoDataPkg::binCount_t modelCnt [`NUM_BINS];
    histoDataPkg::binAddr_t  modelPeakAddr;
    histoDataPkg::binCount_t modelPeakCount;
    int     modelAcqCnt;
    logic   expFlag;
    int     valueErrors;
    int     strobeErrors;
    integer seed;

    sifhHistogram u_dut (
        .clk(clk), .res(res), .hit(hit), .hitTime(hitTime), .mode(mode),
        .fineOffset(fineOffset), .acqEnd(acqEnd), .binValid(binValid),
        .binAddr(binAddr), .binCount(binCount), .peakValid(peakValid),
        .peakAddr(peakAddr), .peakCount(peakCount), .nextFlag(nextFlag), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TEST_CYCLES * 3 * PERIOD);
        $display("Watchdog expired after %0d cycles, the run is stopped", TEST_CYCLES * 3);
        $display("Verification failed");
        $finish;
    end

    task automatic checkAddr(input string name, input histoDataPkg::binAddr_t got,
                             input histoDataPkg::binAddr_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input histoDataPkg::binCount_t got,
                              input histoDataPkg::binCount_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // -1 means the hit falls outside the fine window
    function automatic int mapBin(input histoDataPkg::timeCode_t t);
        int diff;
        if (mode == histoCtrlPkg::COARSE) begin
            return int'(t) >> (`TDC_W - `NB);
        end
        diff = int'(t) - int'(fineOffset);
        if (diff >= 0 && diff < `NUM_BINS) begin
            return diff;
        end
        return -1;
    endfunction

    task automatic modelHit(input histoDataPkg::timeCode_t t);
        int b;
        b = mapBin(t);
        if (b >= 0) begin
            if (modelCnt[b] != '1) begin
                modelCnt[b] = modelCnt[b] + 1'b1;
            end
            if (modelCnt[b] > modelPeakCount) begin   // first to reach keeps a tie
                modelPeakCount = modelCnt[b];
                modelPeakAddr  = histoDataPkg::binAddr_t'(b);
            end
        end
    endtask

    task automatic modelAcq;
        modelAcqCnt++;
        if (modelAcqCnt == `NUM_ACQ) begin
            modelAcqCnt = 0;
            expFlag     = ~expFlag;
        end
    endtask

    task automatic clearModel;
        for (int i = 0; i < `NUM_BINS; i++) begin
            modelCnt[i] = '0;
        end
        modelPeakAddr  = '0;
        modelPeakCount = '0;
    endtask

    task automatic driveCycle(input logic h, input histoDataPkg::timeCode_t t, input logic a);
        @(posedge clk);
        #5;
        hit     = h;
        hitTime = t;
        acqEnd  = a;
        // busy now is the value the DUT samples with these inputs
        if (!busy) begin
            if (h) modelHit(t);
            if (a) modelAcq();
        end
    endtask

    task automatic setMode(input histoCtrlPkg::histMode_e m, input histoDataPkg::timeCode_t off);
        @(posedge clk);
        #5;
        mode       = m;
        fineOffset = off;
    endtask

    task automatic sendAcqs;
        repeat (`NUM_ACQ) begin
            driveCycle(1'b0, '0, 1'b1);
            checkFlag("busy", busy, 1'b0);   // no early frame end
            driveCycle(1'b0, '0, 1'b0);
        end
    endtask

    task automatic checkReadout;
        int waitCnt;
        waitCnt = 0;
        @(negedge clk);
        while (!binValid && waitCnt < FRAME_CYCLES) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!binValid) begin
            strobeErrors++;
            $display("binValid never came after the frame was completed");
        end else begin
            for (int i = 0; i < `NUM_BINS; i++) begin
                if (!binValid) begin
                    strobeErrors++;
                    $display("binValid missing for bin %0d of the sweep", i);
                end else begin
                    checkAddr("binAddr", binAddr, histoDataPkg::binAddr_t'(i));
                    checkCount("binCount", binCount, modelCnt[i]);
                end
                @(negedge clk);
            end
        end
        waitCnt = 0;
        while (!peakValid && waitCnt < 4) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!peakValid) begin
            strobeErrors++;
            $display("peakValid did not follow the bin readout");
        end else begin
            checkAddr("peakAddr", peakAddr, modelPeakAddr);
            checkCount("peakCount", peakCount, modelPeakCount);
        end
        waitCnt = 0;
        while (busy && waitCnt < 4) begin
            @(negedge clk);
            waitCnt++;
        end
        if (busy) begin
            strobeErrors++;
            $display("busy stayed high after the peak report");
        end
        checkFlag("nextFlag", nextFlag, expFlag);
        clearModel();
    endtask

    task automatic endFrame;
        sendAcqs();
        checkReadout();
    endtask

    task automatic testCoarse;
        setMode(histoCtrlPkg::COARSE, '0);
        // lower half of the code range, so bins 32 and up stay empty
        repeat (200) driveCycle(1'b1, histoDataPkg::timeCode_t'($random(seed)) & 10'h1FF, 1'b0);
        driveCycle(1'b0, '0, 1'b0);
        endFrame();
    endtask

    task automatic testFine;
        setMode(histoCtrlPkg::FINE, 10'd300);
        driveCycle(1'b1, 10'd299, 1'b0);   // just below the window
        driveCycle(1'b1, 10'd300, 1'b0);
        driveCycle(1'b1, 10'd363, 1'b0);
        driveCycle(1'b1, 10'd364, 1'b0);   // just above
        repeat (120) driveCycle(1'b1, 10'd250 + histoDataPkg::timeCode_t'($random(seed) & 32'hFF),
                                1'b0);
        driveCycle(1'b0, '0, 1'b0);
        endFrame();
    endtask

    task automatic testBackToBack;
        setMode(histoCtrlPkg::COARSE, '0);
        repeat (25) driveCycle(1'b1, 10'd80, 1'b0);   // bin 5 every cycle
        driveCycle(1'b0, '0, 1'b0);
        endFrame();
        repeat (10) driveCycle(1'b1, 10'd80, 1'b0);   // must restart from zero
        driveCycle(1'b1, 10'd1000, 1'b0);
        driveCycle(1'b0, '0, 1'b0);
        endFrame();
    endtask

    task automatic testPeakTie;
        repeat (3) begin
            driveCycle(1'b1, 10'd320, 1'b0);   // bin 20 reaches 3 first
            driveCycle(1'b1, 10'd144, 1'b0);   // bin 9
        end
        repeat (2) driveCycle(1'b1, 10'd640, 1'b0);
        driveCycle(1'b0, '0, 1'b0);
        endFrame();
    endtask

    task automatic hitsWhileBusy;
        while (!busy) driveCycle(1'b0, '0, 1'b0);
        for (int k = 0; k < 30; k++) begin
            driveCycle(1'b1, histoDataPkg::timeCode_t'($random(seed)), k[0]);
        end
        driveCycle(1'b0, '0, 1'b0);
    endtask

    task automatic testBusyDrop;
        repeat (15) driveCycle(1'b1, histoDataPkg::timeCode_t'($random(seed)), 1'b0);
        driveCycle(1'b0, '0, 1'b0);
        sendAcqs();
        fork
            checkReadout();
            hitsWhileBusy();
        join
        repeat (12) driveCycle(1'b1, 10'd48, 1'b0);
        driveCycle(1'b0, '0, 1'b0);
        endFrame();
    endtask

    initial begin
        seed         = 32'hf85f;
        valueErrors  = 0;
        strobeErrors = 0;
        modelAcqCnt  = 0;
        expFlag      = 1'b0;
        clearModel();
        res        = 1'b0;
        hit        = 1'b0;
        acqEnd     = 1'b0;
        hitTime    = '0;
        fineOffset = '0;
        mode       = histoCtrlPkg::COARSE;
        repeat (2) @(posedge clk);
        #5;
        res = 1'b1;
        checkFlag("busy", busy, 1'b0);
        checkFlag("nextFlag", nextFlag, 1'b0);
        checkFlag("binValid", binValid, 1'b0);
        checkFlag("peakValid", peakValid, 1'b0);

        testCoarse();
        testFine();
        testBackToBack();
        testPeakTie();
        testBusyDrop();

        // bound properties on the last readout close a cycle or two later
        repeat (3) @(negedge clk);

        $display("Checks done: %0d value errors, %0d strobe errors, %0d assertion failures",
                 valueErrors, strobeErrors, u_dut.uChecker.assertFails);
        if (valueErrors + strobeErrors + u_dut.uChecker.assertFails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb/sifhHistogram_checker.sv ====
`timescale 1ns/1ps

module sifhHistogramChecker (
    input logic clk,
    input logic res,
    input logic binValid,
    input logic peakValid,
    input logic busy,
    input logic nextFlag
);

    int assertFails = 0;    // read by the testbench for its summary

    // bin words and the peak report share no cycle
    noOverlap: assert property (@(posedge clk) disable iff (!res)
        !(binValid && peakValid))
        else begin
            assertFails++;
            $error("binValid and peakValid asserted in the same cycle");
        end

    peakEndsBusy: assert property (@(posedge clk) disable iff (!res)
        peakValid |=> $fell(busy))   // readout closes right after the peak
        else begin
            assertFails++;
            $error("busy did not fall in the cycle after peakValid");
        end

    // frame flag flips on the completing strobe, readout starts next cycle
    flagOnFrame: assert property (@(posedge clk) disable iff (!res)
        (nextFlag != $past(nextFlag)) |=> $rose(busy))
        else begin
            assertFails++;
            $error("nextFlag changed without busy rising");
        end

endmodule

bind sifhHistogram sifhHistogramChecker uChecker (
    .clk(clk),
    .res(res),
    .binValid(binValid),
    .peakValid(peakValid),
    .busy(busy),
    .nextFlag(nextFlag)
);
